// ==== sources.f ====
+incdir+logic
logic/tlul_pkg.sv
logic/mem_pkg.sv
logic/tlul_request_decoder.sv
logic/tlul_word_memory.sv
logic/tlul_response_queue.sv
logic/tlul_slave_monitor.sv
logic/tlul_mem_slave_top.sv
testbench/tlul_mem_slave_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tlul_mem_slave_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tlul_mem_slave_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlul_settings.svh"

module tlul_mem_slave_tb;

    localparam int         NUM_ROWS     = 24;
    localparam int         DEPTH        = `TLUL_QUEUE_DEPTH;
    localparam int         MEM_BYTES    = `TLUL_MEM_WORDS * 4;
    localparam int         SAMPLE_DELAY = 5;
    localparam int         CYCLE_LIMIT  = NUM_ROWS * 20;
    localparam logic [7:0] RANDOM_STALL = 8'hff;

    typedef struct packed {
        logic [2:0]                    opcode;
        logic [3:0]                    size;
        logic [`TLUL_ADDR_WIDTH-1:0]   address;
        logic [3:0]                    mask;
        logic [31:0]                   data;
        logic [`TLUL_SOURCE_WIDTH-1:0] source;
        logic [7:0]                    stall;  // Cycles of low D ready before this response
    } row_t;

    row_t table_rows [NUM_ROWS] = '{
        {tlul_pkg::PUT_FULL_DATA, 4'd2, 32'h000, 4'hf, 32'h1122_3344, 4'd1, 8'd0},
        {tlul_pkg::PUT_FULL_DATA, 4'd2, 32'h004, 4'hf, 32'ha5a5_5a5a, 4'd2, 8'd1},
        {tlul_pkg::PUT_FULL_DATA, 4'd2, 32'h008, 4'hf, 32'hdead_beef, 4'd3, 8'd0},
        {tlul_pkg::PUT_FULL_DATA, 4'd2, 32'h00c, 4'hf, 32'h0f1e_2d3c, 4'd4, 8'd0},
        {tlul_pkg::PUT_FULL_DATA, 4'd2, 32'h0fc, 4'hf, 32'hcafe_f00d, 4'd5, 8'd0},
        {tlul_pkg::GET,           4'd2, 32'h000, 4'hf, 32'h0000_0000, 4'd6, 8'd2},
        {tlul_pkg::PUT_PARTIAL_DATA, 4'd0, 32'h001, 4'h2, 32'h0000_9900, 4'd7, 8'd0},
        {tlul_pkg::PUT_PARTIAL_DATA, 4'd1, 32'h006, 4'hc, 32'h7788_0000, 4'd8, 8'd0},
        {tlul_pkg::GET,           4'd2, 32'h000, 4'hf, 32'h0000_0000, 4'd9, 8'd0},
        {tlul_pkg::GET,           4'd2, 32'h004, 4'hf, 32'h0000_0000, 4'd10, 8'd0},
        {tlul_pkg::GET,           4'd1, 32'h00a, 4'hc, 32'h0000_0000, 4'd11, 8'd0},
        {tlul_pkg::GET,           4'd0, 32'h0ff, 4'h8, 32'h0000_0000, 4'd12, 8'd0},
        {3'd2,                    4'd2, 32'h008, 4'hf, 32'hffff_ffff, 4'd13, 8'd0},  // Bad opcode
        {tlul_pkg::PUT_FULL_DATA, 4'd3, 32'h008, 4'hf, 32'hffff_ffff, 4'd14, 8'd0},
        {tlul_pkg::PUT_PARTIAL_DATA, 4'd1, 32'h009, 4'h6, 32'hffff_ffff, 4'd15, 8'd0},
        {tlul_pkg::PUT_FULL_DATA, 4'd2, 32'h100, 4'hf, 32'hffff_ffff, 4'd0, 8'd0},
        {tlul_pkg::PUT_PARTIAL_DATA, 4'd0, 32'h008, 4'h3, 32'hffff_ffff, 4'd1, 8'd0},
        {tlul_pkg::GET,           4'd2, 32'h008, 4'hf, 32'h0000_0000, 4'd2, 8'd0},
        {tlul_pkg::GET,           4'd2, 32'h004, 4'hf, 32'h0000_0000, 4'd3, 8'd8},  // Fills FIFO
        {tlul_pkg::PUT_PARTIAL_DATA, 4'd2, 32'h00c, 4'h5, 32'h1234_5678, 4'd4, RANDOM_STALL},
        {tlul_pkg::GET,           4'd2, 32'h00c, 4'hf, 32'h0000_0000, 4'd5, RANDOM_STALL},
        {tlul_pkg::PUT_FULL_DATA, 4'd1, 32'h00e, 4'hc, 32'habcd_0000, 4'd6, RANDOM_STALL},
        {tlul_pkg::GET,           4'd2, 32'h0fc, 4'hf, 32'h0000_0000, 4'd7, RANDOM_STALL},
        {tlul_pkg::GET,           4'd2, 32'h00c, 4'hf, 32'h0000_0000, 4'd8, RANDOM_STALL}
    };

    logic                         clk = 1'b0;
    logic                         rst_n;
    tlul_pkg::a_channel_t         a_beat;
    logic                         a_valid;
    logic                         a_ready;
    tlul_pkg::d_channel_t         d_beat;
    logic                         d_valid;
    logic                         d_ready;
    logic [`TLUL_COUNT_WIDTH-1:0] outstanding;

    logic [7:0]           model_bytes [MEM_BYTES];
    tlul_pkg::d_channel_t expect_q [$];
    tlul_pkg::d_channel_t stalled_d;
    logic                 was_stalled = 1'b0;
    logic                 a_ready_low_seen = 1'b0;
    int                   model_count = 0;
    int                   check_count = 0;
    int                   error_count = 0;
    int                   cycle_count = 0;
    integer               seed = 32'h092f0423;

    tlul_mem_slave_top i_tlul_mem_slave_top (
        .slave_clock_i   (clk),
        .slave_reset_i   (rst_n),
        .slave_a_i       (a_beat),
        .slave_a_valid_i (a_valid),
        .slave_a_ready_o (a_ready),
        .slave_d_o       (d_beat),
        .slave_d_valid_o (d_valid),
        .slave_d_ready_i (d_ready),
        .outstanding_o   (outstanding)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic logic beat_is_legal(input row_t r);
        int         span;
        logic [3:0] lanes;
        if (r.opcode != tlul_pkg::GET && r.opcode != tlul_pkg::PUT_FULL_DATA &&
            r.opcode != tlul_pkg::PUT_PARTIAL_DATA) return 1'b0;
        if (r.size > 4'd2) return 1'b0;
        span = 1 << r.size;
        if (r.address % span != 0 || r.address >= MEM_BYTES) return 1'b0;
        lanes = 4'((1 << span) - 1) << r.address[1:0];
        if ((r.mask & ~lanes) != 4'h0) return 1'b0;
        return r.opcode != tlul_pkg::PUT_FULL_DATA || r.mask == lanes;
    endfunction

    // Queues the expected response and updates the model memory in acceptance order
    task automatic predict_response(input row_t r);
        tlul_pkg::d_channel_t resp;
        logic                 legal;
        int                   base;
        legal = beat_is_legal(r);
        base = int'({r.address[31:2], 2'b00});
        resp = '0;
        resp.opcode = (r.opcode == tlul_pkg::GET) ? tlul_pkg::ACCESS_ACK_DATA
                                                  : tlul_pkg::ACCESS_ACK;
        resp.size = r.size;
        resp.source = r.source;
        resp.denied = !legal;
        for (int lane = 0; lane < 4; lane++) begin
            if (legal && r.opcode == tlul_pkg::GET) begin
                resp.data[8*lane +: 8] = model_bytes[base + lane];
            end else if (legal && r.mask[lane]) begin
                model_bytes[base + lane] = r.data[8*lane +: 8];
            end
        end
        expect_q.push_back(resp);
    endtask

    task automatic compare_response();
        tlul_pkg::d_channel_t expected;
        if (expect_q.size() == 0) begin
            error_count++;
            $display("Error at %0d ns: a response came out with no request waiting", $time);
            return;
        end
        expected = expect_q.pop_front();
        check_value("slave_d_o.opcode", 64'(d_beat.opcode), 64'(expected.opcode));
        check_value("slave_d_o.param", 64'(d_beat.param), 64'(expected.param));
        check_value("slave_d_o.size", 64'(d_beat.size), 64'(expected.size));
        check_value("slave_d_o.source", 64'(d_beat.source), 64'(expected.source));
        check_value("slave_d_o.denied", 64'(d_beat.denied), 64'(expected.denied));
        check_value("slave_d_o.data", 64'(d_beat.data), 64'(expected.data));
        check_value("slave_d_o.corrupt", 64'(d_beat.corrupt), 64'(expected.corrupt));
    endtask

    task automatic send_beats();
        logic accepted;
        @(negedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            a_beat = '{opcode: table_rows[i].opcode, param: 3'd0, size: table_rows[i].size,
                       source: table_rows[i].source, address: table_rows[i].address,
                       mask: table_rows[i].mask, data: table_rows[i].data, corrupt: 1'b0};
            a_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                #(SAMPLE_DELAY);
                if (a_ready) begin
                    accepted = 1'b1;
                    predict_response(table_rows[i]);
                end
                @(negedge clk);
            end
        end
        a_valid = 1'b0;
        a_beat = '0;
    endtask

    task automatic take_responses();
        int   stall;
        logic taken;
        @(negedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            stall = table_rows[i].stall;
            if (table_rows[i].stall == RANDOM_STALL) stall = $unsigned($random(seed)) % 4;
            d_ready = (stall == 0);
            repeat (stall) @(negedge clk);
            d_ready = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                #(SAMPLE_DELAY);
                if (d_valid) begin
                    taken = 1'b1;
                    compare_response();
                end
                @(negedge clk);
            end
        end
        d_ready = 1'b0;
    endtask

    // Runs just before each rising edge where every signal has settled
    task automatic sample_bus();
        logic a_fire;
        logic d_fire;
        a_fire = a_valid && a_ready;
        d_fire = d_valid && d_ready;
        check_value("outstanding_o", 64'(outstanding), 64'(model_count));
        check_value("outstanding_o <= depth", 64'(outstanding <= DEPTH), 64'd1);
        check_value("slave_a_ready_o", 64'(a_ready), 64'(model_count < DEPTH));
        check_value("slave_d_valid_o", 64'(d_valid), 64'(model_count != 0));
        if (!a_ready) a_ready_low_seen = 1'b1;
        if (was_stalled) begin
            check_value("slave_d_valid_o", 64'(d_valid), 64'd1);
            check_value("slave_d_o", 64'(d_beat), 64'(stalled_d));
        end
        was_stalled = d_valid && !d_ready;
        stalled_d = d_beat;
        model_count = model_count + int'(a_fire) - int'(d_fire);
    endtask

    initial begin
        forever begin
            @(negedge clk);
            #(SAMPLE_DELAY);
            if (rst_n) sample_bus();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: responses still missing after %0d cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        a_valid = 1'b0;
        a_beat = '0;
        d_ready = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        #(SAMPLE_DELAY);
        check_value("slave_d_valid_o", 64'(d_valid), 64'd0);
        check_value("slave_a_ready_o", 64'(a_ready), 64'd1);
        check_value("outstanding_o", 64'(outstanding), 64'd0);
        fork
            send_beats();
            take_responses();
        join
        repeat (2) @(negedge clk);
        if (!a_ready_low_seen) begin
            error_count++;
            $display("Error: A ready never fell while D ready was held low");
        end
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/tlul_mem_slave_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlul_settings.svh"

module tlul_mem_slave_top (
    input  wire logic                    slave_clock_i,
    input  wire logic                    slave_reset_i,
    input  wire tlul_pkg::a_channel_t    slave_a_i,
    input  wire logic                    slave_a_valid_i,
    output logic                         slave_a_ready_o,
    output tlul_pkg::d_channel_t         slave_d_o,
    output logic                         slave_d_valid_o,
    input  wire logic                    slave_d_ready_i,
    output logic [`TLUL_COUNT_WIDTH-1:0] outstanding_o
);

    logic                 a_fire;
    logic                 get_data;
    logic [31:0]          read_data;
    mem_pkg::mem_access_t access;
    mem_pkg::resp_entry_t header;
    mem_pkg::resp_entry_t queue_entry;

    assign a_fire   = slave_a_valid_i && slave_a_ready_o;
    assign get_data = header.opcode == tlul_pkg::ACCESS_ACK_DATA && !header.denied;

    tlul_request_decoder i_request_decoder (
        .a_beat_i (slave_a_i),
        .a_fire_i (a_fire),
        .access_o (access),
        .resp_o   (header)
    );

    tlul_word_memory i_word_memory (
        .slave_clock_i (slave_clock_i),
        .access_i      (access),
        .read_data_o   (read_data)
    );

    // Only a legal Get carries memory data back
    assign queue_entry = '{
        opcode:  header.opcode,
        param:   header.param,
        size:    header.size,
        source:  header.source,
        denied:  header.denied,
        data:    get_data ? read_data : 32'h0000_0000,
        corrupt: header.corrupt
    };

    tlul_response_queue i_response_queue (
        .slave_clock_i (slave_clock_i),
        .slave_reset_i (slave_reset_i),
        .push_i        (a_fire),
        .entry_i       (queue_entry),
        .d_ready_i     (slave_d_ready_i),
        .not_full_o    (slave_a_ready_o),
        .d_o           (slave_d_o),
        .d_valid_o     (slave_d_valid_o)
    );

    tlul_slave_monitor i_slave_monitor (
        .slave_clock_i (slave_clock_i),
        .slave_reset_i (slave_reset_i),
        .a_valid_i     (slave_a_valid_i),
        .a_ready_i     (slave_a_ready_o),
        .d_i           (slave_d_o),
        .d_valid_i     (slave_d_valid_o),
        .d_ready_i     (slave_d_ready_i),
        .outstanding_o (outstanding_o)
    );

endmodule

`default_nettype wire

// ==== logic/tlul_slave_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlul_settings.svh"

module tlul_slave_monitor (
    input  wire logic                 slave_clock_i,
    input  wire logic                 slave_reset_i,
    input  wire logic                 a_valid_i,
    input  wire logic                 a_ready_i,
    input  wire tlul_pkg::d_channel_t d_i,
    input  wire logic                 d_valid_i,
    input  wire logic                 d_ready_i,
    output logic [`TLUL_COUNT_WIDTH-1:0] outstanding_o
);

    logic                         past_valid;
    logic                         a_fire;
    logic                         d_fire;
    logic [`TLUL_COUNT_WIDTH-1:0] count;

    assign a_fire = a_valid_i && a_ready_i;
    assign d_fire = d_valid_i && d_ready_i;

    // Marks that $past has a defined history to look at
    always_ff @(posedge slave_clock_i) begin
        if (!slave_reset_i) begin
            past_valid <= 1'b0;
        end else begin
            past_valid <= 1'b1;
        end
    end

    always_ff @(posedge slave_clock_i) begin
        if (!slave_reset_i) begin
            count <= '0;
        end else begin
            case ({a_fire, d_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign outstanding_o = count;

    count_limit: assert property (
        @(posedge slave_clock_i) disable iff (!slave_reset_i)
        count <= `TLUL_COUNT_WIDTH'(`TLUL_QUEUE_DEPTH)
    );

    // Every response must answer an earlier request
    no_orphan_response: assert property (
        @(posedge slave_clock_i) disable iff (!slave_reset_i)
        d_fire |-> count != '0
    );

    // A stalled D beat keeps its fields and its valid until taken
    d_stable_when_stalled: assert property (
        @(posedge slave_clock_i) disable iff (!slave_reset_i)
        past_valid && $past(d_valid_i && !d_ready_i && slave_reset_i)
            |-> $stable(d_i) && d_valid_i
    );

endmodule

`default_nettype wire

// ==== logic/tlul_response_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlul_settings.svh"

module tlul_response_queue (
    input  wire logic                 slave_clock_i,
    input  wire logic                 slave_reset_i,
    input  wire logic                 push_i,
    input  wire mem_pkg::resp_entry_t entry_i,
    input  wire logic                 d_ready_i,
    output logic                      not_full_o,
    output tlul_pkg::d_channel_t      d_o,
    output logic                      d_valid_o
);

    localparam int PTR_WIDTH = $clog2(`TLUL_QUEUE_DEPTH);

    mem_pkg::resp_entry_t          entries [`TLUL_QUEUE_DEPTH];
    mem_pkg::resp_entry_t          head;
    logic [PTR_WIDTH-1:0]          rd_ptr;
    logic [PTR_WIDTH-1:0]          wr_ptr;
    logic [`TLUL_COUNT_WIDTH-1:0]  count;
    logic                          pop;

    assign pop        = d_valid_o && d_ready_i;
    assign d_valid_o  = count != '0;
    assign not_full_o = count != `TLUL_COUNT_WIDTH'(`TLUL_QUEUE_DEPTH);

    always_ff @(posedge slave_clock_i) begin
        if (!slave_reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(`TLUL_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(`TLUL_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Push and pop together keep the level
            endcase
        end
    end

    always_ff @(posedge slave_clock_i) begin
        if (push_i) begin
            entries[wr_ptr] <= entry_i;
        end
    end

    assign head = entries[rd_ptr];

    assign d_o = '{
        opcode:  head.opcode,
        param:   head.param,
        size:    head.size,
        source:  head.source,
        denied:  head.denied,
        data:    head.data,
        corrupt: head.corrupt
    };

    // The A side must respect back-pressure
    push_when_full: assert property (
        @(posedge slave_clock_i) disable iff (!slave_reset_i)
        push_i |-> not_full_o
    );

endmodule

`default_nettype wire

// ==== logic/tlul_word_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlul_settings.svh"

module tlul_word_memory (
    input  wire logic                 slave_clock_i,
    input  wire mem_pkg::mem_access_t access_i,
    output logic [31:0]               read_data_o
);

    logic [31:0] words [`TLUL_MEM_WORDS];

    always_ff @(posedge slave_clock_i) begin
        if (access_i.enable && access_i.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (access_i.strobe[lane]) begin
                    words[access_i.index][8*lane +: 8] <= access_i.wdata[8*lane +: 8];
                end
            end
        end
    end

    // Get sees the word as it was before this edge
    assign read_data_o = words[access_i.index];

endmodule

`default_nettype wire

// ==== logic/tlul_request_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlul_settings.svh"

module tlul_request_decoder (
    input  wire tlul_pkg::a_channel_t a_beat_i,
    input  wire logic                 a_fire_i,
    output mem_pkg::mem_access_t      access_o,
    output mem_pkg::resp_entry_t      resp_o
);

    localparam int INDEX_WIDTH = $clog2(`TLUL_MEM_WORDS);

    logic       is_get;
    logic       is_put_full;
    logic       is_put_partial;
    logic       opcode_ok;
    logic       size_ok;
    logic       align_ok;
    logic       range_ok;
    logic       mask_ok;
    logic       legal;
    logic [3:0] lanes;

    assign is_get         = a_beat_i.opcode == tlul_pkg::GET;
    assign is_put_full    = a_beat_i.opcode == tlul_pkg::PUT_FULL_DATA;
    assign is_put_partial = a_beat_i.opcode == tlul_pkg::PUT_PARTIAL_DATA;
    assign opcode_ok      = is_get || is_put_full || is_put_partial;
    assign size_ok        = a_beat_i.size <= 4'd2;

    assign align_ok = (a_beat_i.size == 4'd0) ||
                      (a_beat_i.size == 4'd1 && !a_beat_i.address[0]) ||
                      (a_beat_i.size == 4'd2 && a_beat_i.address[1:0] == 2'b00);

    // Everything above the word index must be zero
    assign range_ok = a_beat_i.address[`TLUL_ADDR_WIDTH-1:INDEX_WIDTH+2] == '0;

    always_comb begin
        case (a_beat_i.size)
            4'd0:    lanes = 4'b0001 << a_beat_i.address[1:0];
            4'd1:    lanes = 4'b0011 << a_beat_i.address[1:0];
            4'd2:    lanes = 4'b1111;
            default: lanes = 4'b0000;
        endcase
    end

    // A full put must cover its lanes exactly
    assign mask_ok = ((a_beat_i.mask & ~lanes) == 4'b0000) &&
                     (!is_put_full || a_beat_i.mask == lanes);

    assign legal = opcode_ok && size_ok && align_ok && range_ok && mask_ok;

    always_comb begin
        access_o.enable = a_fire_i && legal;
        access_o.write  = is_put_full || is_put_partial;
        access_o.index  = a_beat_i.address[INDEX_WIDTH+1:2];
        access_o.strobe = access_o.write ? a_beat_i.mask : 4'b0000;
        access_o.wdata  = a_beat_i.data;
    end

    always_comb begin
        resp_o.opcode  = is_get ? tlul_pkg::ACCESS_ACK_DATA : tlul_pkg::ACCESS_ACK;
        resp_o.param   = 2'b00;
        resp_o.size    = a_beat_i.size;
        resp_o.source  = a_beat_i.source;
        resp_o.denied  = !legal;
        resp_o.data    = 32'h0000_0000;  // Read data is merged in at the FIFO input
        resp_o.corrupt = 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

`include "tlul_settings.svh"

package mem_pkg;

    // One memory operation formed from an accepted A beat
    typedef struct packed {
        logic                                enable;
        logic                                write;
        logic [$clog2(`TLUL_MEM_WORDS)-1:0]  index;
        logic [3:0]                          strobe;
        logic [31:0]                         wdata;
    } mem_access_t;

    // A D response as it waits in the FIFO
    typedef struct packed {
        tlul_pkg::d_opcode_e           opcode;
        logic [1:0]                    param;
        logic [3:0]                    size;
        logic [`TLUL_SOURCE_WIDTH-1:0] source;
        logic                          denied;
        logic [31:0]                   data;
        logic                          corrupt;
    } resp_entry_t;

endpackage

`default_nettype wire

// ==== logic/tlul_pkg.sv ====
`default_nettype none

`include "tlul_settings.svh"

package tlul_pkg;

    typedef enum logic [2:0] {
        PUT_FULL_DATA    = 3'd0,
        PUT_PARTIAL_DATA = 3'd1,
        GET              = 3'd4
    } a_opcode_e;

    typedef enum logic [2:0] {
        ACCESS_ACK      = 3'd0,
        ACCESS_ACK_DATA = 3'd1
    } d_opcode_e;

    typedef struct packed {
        logic [2:0]                    opcode;  // Raw code because a master may send unsupported values
        logic [2:0]                    param;
        logic [3:0]                    size;
        logic [`TLUL_SOURCE_WIDTH-1:0] source;
        logic [`TLUL_ADDR_WIDTH-1:0]   address;
        logic [3:0]                    mask;
        logic [31:0]                   data;
        logic                          corrupt;
    } a_channel_t;

    typedef struct packed {
        d_opcode_e                     opcode;
        logic [1:0]                    param;
        logic [3:0]                    size;
        logic [`TLUL_SOURCE_WIDTH-1:0] source;
        logic                          denied;
        logic [31:0]                   data;
        logic                          corrupt;
    } d_channel_t;

endpackage

`default_nettype wire

// ==== logic/tlul_settings.svh ====
`ifndef TLUL_SETTINGS_SVH
`define TLUL_SETTINGS_SVH

// Bus geometry
`define TLUL_ADDR_WIDTH 32
`define TLUL_SOURCE_WIDTH 4

// Memory depth in 32-bit words must be a power of two
`define TLUL_MEM_WORDS 64

// Response FIFO depth is also the outstanding transaction limit
`define TLUL_QUEUE_DEPTH 2

// Holds 0 up to the queue depth
`define TLUL_COUNT_WIDTH 2

`endif
